//--- csr_unit.f
+incdir+dv
rtl/csr_types_pkg.sv
rtl/csr_map_pkg.sv
rtl/csr_counter64.sv
rtl/csr_counters.sv
rtl/csr_trap_regs.sv
rtl/csr_access.sv
rtl/csr_top.sv
dv/csr_tb.sv

//--- dv/csr_cases.txt
# keyword, index or operands in hex, expected value in hex (IDLE and RET counts decimal)
# r = random write data from the lfsr, m = expected value from the write model
RD 300 00001800
IRQEN 0
WR 305 r
WR 340 r
WR 304 r
WR 342 r
WR 343 r
WR 341 r
RD 305 m
RD 340 m
RD 304 m
RD 342 m
RD 343 m
RD 341 m
MTVEC m
MEPC m
IRQEN m
WR 304 ffffffff
RD 304 00000888
WR 342 ffffffff
RD 342 8000000f
WR 341 ffffffff
RD 341 fffffffe
WR 300 00000008
RD 300 00001808
IRQEN f
TRAPW 80000101 800000f7 00000123 55555555
RD 300 00001880
RD 341 80000100
RD 342 80000007
RD 343 00000123
MEPC 80000100
IRQEN 7
MRET
RD 300 00001888
IRQEN f
IRQ 4
RD 344 00000800
IRQ 2
RD 344 00000008
IRQ 1
RD 344 00000080
IRQ 0
RD 344 00000000
WR b80 00000000
WR b00 fffffffe
RD b00 fffffffe
RD b80 00000000
RD b80 00000001
RD b00 00000001
WR b02 00000000
RET 5
RD b02 00000005
WR b02 ffffffff
RET 1
RD b82 00000001
RD b02 00000000
WR bff 00000007
RD bff 00000005
WR b00 00001234
IDLE 3
RD b00 00001234
WR b02 00000010
RET 3
RD b02 00000010
WR bff 00000000
RET 2
RD b02 00000012
RD 301 m
RD f11 m
RD f12 m
RD f13 m
RD f14 m
WR 301 ffffffff
RD 301 m
WR 7c0 ffffffff
RD 7c0 00000000
RDOFF 300

//--- dv/csr_tb_checks.svh
`ifndef CSR_TB_CHECKS_SVH
`define CSR_TB_CHECKS_SVH

   ////////////////////////////////////////
   // random write data
   ////////////////////////////////////////
   logic [15:0] lfsr_state = 16'd50090;

   // galois form, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb         = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (fb)
         lfsr_state = lfsr_state ^ 16'hB400;
      return fb;
   endfunction

   // one lfsr step per bit
   function automatic xlen_t rand_word();
      xlen_t w;
      w = '0;
      for (int i = 0; i < XLEN; i++)
         w = {w[XLEN-2:0], lfsr_bit()};
      return w;
   endfunction

   ////////////////////////////////////////
   // failure exit
   ////////////////////////////////////////
   task automatic report_fail(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   ////////////////////////////////////////
   // compare tasks, one per result kind
   ////////////////////////////////////////
   task automatic check_rdata(input csr_idx_t idx, input xlen_t got, input xlen_t exp);
      if (got !== exp)
         report_fail($sformatf("Mismatch at %0t: rdata (idx 0x%03h) got 0x%08h exp 0x%08h",
                               $time, idx, got, exp));
   endtask

   task automatic check_irq_en(input irq_en_t got, input irq_en_t exp);
      if (got !== exp)
         report_fail($sformatf("Mismatch at %0t: irq_en got 0x%01h exp 0x%01h",
                               $time, got, exp));
   endtask

   // mtvec and mepc level outputs
   task automatic check_pc(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp)
         report_fail($sformatf("Mismatch at %0t: %s got 0x%08h exp 0x%08h",
                               $time, name, got, exp));
   endtask

`endif

//--- dv/csr_tb.sv
`default_nettype none
`timescale 1ns/1ps

module csr_tb
   import csr_types_pkg::*, csr_map_pkg::*;
();

   localparam int    CLK_PERIOD = 10;
   localparam int    RST_CYCLES = 10;
   localparam int    WD_SLACK   = 100;   // spare cycles on top of the cases
   localparam string CASE_FILE  = "dv/csr_cases.txt";

   logic     clk;
   logic     rst_n;
   csr_req_t csr_req;
   xlen_t    rdata;
   cmt_t     cmt;
   irq_t     irq;
   irq_en_t  irq_en;
   xlen_t    mtvec;
   xlen_t    mepc;

   string  case_lines[$];          // stimulus lines without comment lines
   longint total_cycles = 0;
   logic   cases_loaded = 1'b0;
   xlen_t  exp_model [0:4095];     // expected read value per index

   `include "csr_tb_checks.svh"

   csr_top uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .csr_req (csr_req),
      .rdata   (rdata),
      .cmt     (cmt),
      .irq     (irq),
      .hart_id (1'b1),
      .irq_en  (irq_en),
      .mtvec   (mtvec),
      .mepc    (mepc)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // expected values from the field rules
   ////////////////////////////////////////
   function automatic void init_model();
      foreach (exp_model[i])
         exp_model[i] = '0;
      exp_model[ADDR_MSTATUS]   = 32'h0000_1800;   // mpp = machine
      exp_model[ADDR_MISA]      = MISA_VALUE;
      exp_model[ADDR_MVENDORID] = VENDOR_ID;
      exp_model[ADDR_MARCHID]   = ARCH_ID;
      exp_model[ADDR_MIMPID]    = IMP_ID;
      exp_model[ADDR_MHARTID]   = 32'h0000_0001;   // hart_id tied high
   endfunction

   function automatic void apply_write(input csr_idx_t idx, input xlen_t d);
      case (idx)
         ADDR_MSTATUS:     exp_model[idx] = (d & 32'h0000_0088) | 32'h0000_1800;
         ADDR_MIE:         exp_model[idx] = d & 32'h0000_0888;   // mei, mti, msi
         ADDR_MEPC:        exp_model[idx] = d & 32'hFFFF_FFFE;
         ADDR_MCAUSE:      exp_model[idx] = d & 32'h8000_000F;
         ADDR_COUNTERSTOP: exp_model[idx] = d & 32'h0000_0005;
         ADDR_MTVEC, ADDR_MSCRATCH, ADDR_MTVAL,
         ADDR_MCYCLE, ADDR_MCYCLEH, ADDR_MINSTRET, ADDR_MINSTRETH:
            exp_model[idx] = d;
         default: ;   // read only or unmapped index drops the write
      endcase
   endfunction

   // enables as the last mstatus and mie writes left them
   function automatic logic [3:0] model_irq_en();
      return {exp_model[ADDR_MSTATUS][MSTATUS_MIE_BIT], exp_model[ADDR_MIE][MEI_BIT],
              exp_model[ADDR_MIE][MTI_BIT], exp_model[ADDR_MIE][MSI_BIT]};
   endfunction

   // hex literal or m for the model value
   function automatic xlen_t exp_value(input string tok, input xlen_t model_val);
      xlen_t v;
      v = '0;
      if (tok == "m")
         return model_val;
      void'($sscanf(tok, "%h", v));
      return v;
   endfunction

   ////////////////////////////////////////
   // case file
   ////////////////////////////////////////
   task automatic load_cases();
      int    fd;
      int    cnt;
      string line;
      string op;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         report_fail($sformatf("could not open the case file %s", CASE_FILE));
      end else begin
         while ($fgets(line, fd) > 0) begin
            op = "";
            if ($sscanf(line, "%s", op) == 1 && op.substr(0, 0) != "#") begin
               case_lines.push_back(line);
               if (op == "IDLE" || op == "RET") begin
                  void'($sscanf(line, "%s %d", op, cnt));
                  total_cycles += cnt;
               end else begin
                  total_cycles += 1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////////////////////////
   // stimulus driver
   ////////////////////////////////////////
   task automatic next_cycle();
      @(posedge clk);
      #1;
      csr_req = '0;   // strobes last one cycle
      cmt     = '0;
   endtask

   task automatic sample_point();
      #(CLK_PERIOD - 2);   // 1 ns before the next rising edge
   endtask

   task automatic run_case(input string line);
      string      op;
      string      tok;
      csr_idx_t   idx;
      xlen_t      v0;
      xlen_t      v1;
      xlen_t      v2;
      xlen_t      v3;
      int         cnt;
      logic [3:0] en_v;
      tok = "";
      void'($sscanf(line, "%s", op));
      if (op == "WR") begin
         void'($sscanf(line, "%s %h %s", op, idx, tok));
         if (tok == "r")
            v0 = rand_word();
         else
            v0 = exp_value(tok, '0);
         next_cycle();
         csr_req.ena   = 1'b1;
         csr_req.wr_en = 1'b1;
         csr_req.idx   = idx;
         csr_req.wdata = v0;
         apply_write(idx, v0);
         sample_point();
      end else if (op == "RD" || op == "RDOFF") begin
         void'($sscanf(line, "%s %h %s", op, idx, tok));
         next_cycle();
         csr_req.ena   = 1'b1;
         csr_req.rd_en = (op == "RD");   // rdoff keeps rd_en low
         csr_req.idx   = idx;
         sample_point();
         if (op == "RD")
            check_rdata(idx, rdata, exp_value(tok, exp_model[idx]));
         else
            check_rdata(idx, rdata, '0);
      end else if (op == "TRAP" || op == "TRAPW") begin
         void'($sscanf(line, "%s %h %h %h %h", op, v0, v1, v2, v3));
         next_cycle();
         cmt.status_ena  = 1'b1;
         cmt.epc_ena     = 1'b1;
         cmt.epc         = v0;
         cmt.cause_ena   = 1'b1;
         cmt.cause       = v1;
         cmt.badaddr_ena = 1'b1;
         cmt.badaddr     = v2;
         if (op == "TRAPW") begin   // mepc write in the commit cycle
            csr_req.ena   = 1'b1;
            csr_req.wr_en = 1'b1;
            csr_req.idx   = ADDR_MEPC;
            csr_req.wdata = v3;
         end
         sample_point();
      end else if (op == "MRET") begin
         next_cycle();
         cmt.mret_ena = 1'b1;
         sample_point();
      end else if (op == "IRQ") begin
         void'($sscanf(line, "%s %h", op, v0));
         next_cycle();
         irq = irq_t'(v0[2:0]);   // {ext, sft, tmr} held as a level
         sample_point();
      end else if (op == "IDLE" || op == "RET") begin
         void'($sscanf(line, "%s %d", op, cnt));
         repeat (cnt) begin
            next_cycle();
            cmt.instret_ena = (op == "RET");
            sample_point();
         end
      end else if (op == "IRQEN") begin
         void'($sscanf(line, "%s %s", op, tok));
         next_cycle();
         sample_point();
         if (tok == "m") begin
            en_v = model_irq_en();
         end else begin
            v0   = exp_value(tok, '0);
            en_v = v0[3:0];
         end
         check_irq_en(irq_en, irq_en_t'(en_v));
      end else if (op == "MTVEC" || op == "MEPC") begin
         void'($sscanf(line, "%s %s", op, tok));
         next_cycle();
         sample_point();
         if (op == "MTVEC")
            check_pc("mtvec", mtvec, exp_value(tok, exp_model[ADDR_MTVEC]));
         else
            check_pc("mepc", mepc, exp_value(tok, exp_model[ADDR_MEPC]));
      end else begin
         report_fail($sformatf("unknown keyword %s in the case file", op));
      end
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////
   initial begin
      rst_n   = 1'b0;
      csr_req = '0;
      cmt     = '0;
      irq     = '0;
      init_model();
      load_cases();
      cases_loaded = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      foreach (case_lines[i])
         run_case(case_lines[i]);
      @(posedge clk);
      $display("Done: no errors");
      $finish;
   end

   initial begin
      longint limit_ns;
      wait (cases_loaded);
      limit_ns = (RST_CYCLES + total_cycles + WD_SLACK) * CLK_PERIOD;
      #(limit_ns);
      report_fail($sformatf("watchdog expired after %0d ns before the cases finished",
                            limit_ns));
   end

endmodule

`default_nettype wire

//--- rtl/csr_access.sv
`default_nettype none
`timescale 1ns/1ps

module csr_access
   import csr_types_pkg::*, csr_map_pkg::*;
#(
   parameter int unsigned HART_ID_W = 1
) (
   input  csr_req_t             csr_req,
   input  trap_view_t           trap_view,
   input  cnt_view_t            cnt_view,
   input  logic [HART_ID_W-1:0] hart_id,
   output csr_wr_sel_t          wr_sel,
   output xlen_t                rdata
);

   // gate a register value onto the read or-tree
   function automatic xlen_t rd_term(input logic hit, input xlen_t val);
      return {XLEN{hit}} & val;
   endfunction

   csr_idx_t idx;
   logic     wen; // qualified write
   logic     ren; // qualified read
   xlen_t    mhartid;

   assign idx = csr_req.idx;
   assign wen = csr_req.ena & csr_req.wr_en;
   assign ren = csr_req.ena & csr_req.rd_en;

   assign mhartid = xlen_t'(hart_id); // zero extend

   ////////////////////////////////////////
   // write strobes
   ////////////////////////////////////////
   // read-only and unmapped indices get no strobe, so writes drop
   always_comb begin
      wr_sel             = '0;
      wr_sel.mstatus     = wen & (idx == ADDR_MSTATUS);
      wr_sel.mie         = wen & (idx == ADDR_MIE);
      wr_sel.mtvec       = wen & (idx == ADDR_MTVEC);
      wr_sel.mscratch    = wen & (idx == ADDR_MSCRATCH);
      wr_sel.mepc        = wen & (idx == ADDR_MEPC);
      wr_sel.mcause      = wen & (idx == ADDR_MCAUSE);
      wr_sel.mtval       = wen & (idx == ADDR_MTVAL);
      wr_sel.mcycle      = wen & (idx == ADDR_MCYCLE);
      wr_sel.mcycleh     = wen & (idx == ADDR_MCYCLEH);
      wr_sel.minstret    = wen & (idx == ADDR_MINSTRET);
      wr_sel.minstreth   = wen & (idx == ADDR_MINSTRETH);
      wr_sel.counterstop = wen & (idx == ADDR_COUNTERSTOP);
   end

   ////////////////////////////////////////
   // read mux, and-or style
   ////////////////////////////////////////
   always_comb begin
      rdata = '0;
      // trap state
      rdata |= rd_term(ren & (idx == ADDR_MSTATUS),     trap_view.mstatus);
      rdata |= rd_term(ren & (idx == ADDR_MIE),         trap_view.mie);
      rdata |= rd_term(ren & (idx == ADDR_MIP),         trap_view.mip);
      rdata |= rd_term(ren & (idx == ADDR_MTVEC),       trap_view.mtvec);
      rdata |= rd_term(ren & (idx == ADDR_MSCRATCH),    trap_view.mscratch);
      rdata |= rd_term(ren & (idx == ADDR_MEPC),        trap_view.mepc);
      rdata |= rd_term(ren & (idx == ADDR_MCAUSE),      trap_view.mcause);
      rdata |= rd_term(ren & (idx == ADDR_MTVAL),       trap_view.mtval);
      // counters
      rdata |= rd_term(ren & (idx == ADDR_MCYCLE),      cnt_view.mcycle);
      rdata |= rd_term(ren & (idx == ADDR_MCYCLEH),     cnt_view.mcycleh);
      rdata |= rd_term(ren & (idx == ADDR_MINSTRET),    cnt_view.minstret);
      rdata |= rd_term(ren & (idx == ADDR_MINSTRETH),   cnt_view.minstreth);
      rdata |= rd_term(ren & (idx == ADDR_COUNTERSTOP), cnt_view.counterstop);
      // information registers, read only
      rdata |= rd_term(ren & (idx == ADDR_MISA),        MISA_VALUE);
      rdata |= rd_term(ren & (idx == ADDR_MVENDORID),   VENDOR_ID);
      rdata |= rd_term(ren & (idx == ADDR_MARCHID),     ARCH_ID);
      rdata |= rd_term(ren & (idx == ADDR_MIMPID),      IMP_ID);
      rdata |= rd_term(ren & (idx == ADDR_MHARTID),     mhartid);
   end

endmodule

`default_nettype wire

//--- rtl/csr_counter64.sv
`default_nettype none
`timescale 1ns/1ps

module csr_counter64
   import csr_types_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   wr_lo,   // csr write of low half
   input  logic   wr_hi,   // csr write of high half
   input  xlen_t  wdata,
   input  logic   inc,     // count enable, stop already applied
   output cnt64_t cnt
);

   xlen_t lo_r;
   xlen_t hi_r;
   logic  lo_full;   // low half about to wrap

   assign lo_full = &lo_r;

   ////////////////////////////////////////
   // low / high halves
   ////////////////////////////////////////
   // a write replaces the increment of its own half only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lo_r <= '0;
         hi_r <= '0;
      end else begin
         if (wr_lo)
            lo_r <= wdata;
         else if (inc)
            lo_r <= lo_r + 1'b1;

         if (wr_hi)
            hi_r <= wdata;
         else if (inc && lo_full)
            hi_r <= hi_r + 1'b1;   // carry from low half
      end
   end

   assign cnt = {hi_r, lo_r};

endmodule

`default_nettype wire

//--- rtl/csr_counters.sv
`default_nettype none
`timescale 1ns/1ps

module csr_counters
   import csr_types_pkg::*, csr_map_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  csr_wr_sel_t wr_sel,
   input  xlen_t       wdata,
   input  logic        instret_ena,
   output cnt_view_t   cnt_view
);

   logic   cy_stop_r;   // freeze mcycle
   logic   ir_stop_r;   // freeze minstret
   cnt64_t cycle_val;
   cnt64_t instret_val;

   // counterstop, bits 0 and 2 only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cy_stop_r <= 1'b0;
         ir_stop_r <= 1'b0;
      end else if (wr_sel.counterstop) begin
         cy_stop_r <= wdata[CY_STOP_BIT];
         ir_stop_r <= wdata[IR_STOP_BIT];
      end
   end

   csr_counter64 cycle_cnt (
      .clk   (clk),
      .rst_n (rst_n),
      .wr_lo (wr_sel.mcycle),
      .wr_hi (wr_sel.mcycleh),
      .wdata (wdata),
      .inc   (~cy_stop_r),        // free running
      .cnt   (cycle_val)
   );

   csr_counter64 instret_cnt (
      .clk   (clk),
      .rst_n (rst_n),
      .wr_lo (wr_sel.minstret),
      .wr_hi (wr_sel.minstreth),
      .wdata (wdata),
      .inc   (instret_ena & ~ir_stop_r),
      .cnt   (instret_val)
   );

   always_comb begin
      cnt_view                          = '0;
      cnt_view.mcycle                   = cycle_val[XLEN-1:0];
      cnt_view.mcycleh                  = cycle_val[2*XLEN-1:XLEN];
      cnt_view.minstret                 = instret_val[XLEN-1:0];
      cnt_view.minstreth                = instret_val[2*XLEN-1:XLEN];
      cnt_view.counterstop[CY_STOP_BIT] = cy_stop_r;
      cnt_view.counterstop[IR_STOP_BIT] = ir_stop_r;   // time stop bit reads 0
   end

endmodule

`default_nettype wire

//--- rtl/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

   ////////////////////////////////////////
   // machine mode csr addresses
   ////////////////////////////////////////
   localparam logic [11:0] ADDR_MSTATUS     = 12'h300;
   localparam logic [11:0] ADDR_MISA        = 12'h301;
   localparam logic [11:0] ADDR_MIE         = 12'h304;
   localparam logic [11:0] ADDR_MTVEC       = 12'h305;
   localparam logic [11:0] ADDR_MSCRATCH    = 12'h340;
   localparam logic [11:0] ADDR_MEPC        = 12'h341;
   localparam logic [11:0] ADDR_MCAUSE      = 12'h342;
   localparam logic [11:0] ADDR_MTVAL       = 12'h343; // old name mbadaddr
   localparam logic [11:0] ADDR_MIP         = 12'h344;
   localparam logic [11:0] ADDR_MCYCLE      = 12'hB00;
   localparam logic [11:0] ADDR_MINSTRET    = 12'hB02;
   localparam logic [11:0] ADDR_MCYCLEH     = 12'hB80;
   localparam logic [11:0] ADDR_MINSTRETH   = 12'hB82;
   localparam logic [11:0] ADDR_COUNTERSTOP = 12'hBFF; // custom, outside the isa space
   localparam logic [11:0] ADDR_MVENDORID   = 12'hF11;
   localparam logic [11:0] ADDR_MARCHID     = 12'hF12;
   localparam logic [11:0] ADDR_MIMPID      = 12'hF13;
   localparam logic [11:0] ADDR_MHARTID     = 12'hF14;

   ////////////////////////////////////////
   // field positions
   ////////////////////////////////////////
   localparam int unsigned MSTATUS_MIE_BIT  = 3;
   localparam int unsigned MSTATUS_MPIE_BIT = 7;
   localparam int unsigned MSTATUS_MPP_LSB  = 11;      // mpp is bits 12:11
   localparam logic [1:0]  MSTATUS_MPP_VAL  = 2'b11;   // machine mode only

   localparam int unsigned MEI_BIT = 11; // external
   localparam int unsigned MTI_BIT = 7;  // timer
   localparam int unsigned MSI_BIT = 3;  // software

   localparam int unsigned MCAUSE_INT_BIT = 31;
   localparam int unsigned MCAUSE_CODE_W  = 4;  // exception code bits kept

   localparam int unsigned CY_STOP_BIT = 0;  // bit 1 (time) not implemented
   localparam int unsigned IR_STOP_BIT = 2;

   ////////////////////////////////////////
   // identification constants
   ////////////////////////////////////////
   // mxl=1 (rv32), extensions i, m, c
   localparam logic [31:0] MISA_VALUE = 32'h4000_1104;
   localparam logic [31:0] VENDOR_ID  = 32'h0000_0536;
   localparam logic [31:0] ARCH_ID    = 32'h0000_E203;
   localparam logic [31:0] IMP_ID     = 32'h0000_0001;

endpackage

`default_nettype wire

//--- rtl/csr_top.sv
`default_nettype none
`timescale 1ns/1ps

module csr_top
   import csr_types_pkg::*;
#(
   parameter int unsigned PC_W      = 32,
   parameter int unsigned HART_ID_W = 1
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  csr_req_t             csr_req,
   output xlen_t                rdata,
   input  cmt_t                 cmt,
   input  irq_t                 irq,
   input  logic [HART_ID_W-1:0] hart_id,
   output irq_en_t              irq_en,
   output xlen_t                mtvec,
   output xlen_t                mepc
);

   csr_wr_sel_t wr_sel;      // decoded write strobes
   trap_view_t  trap_view;
   cnt_view_t   cnt_view;

   ////////////////////////////////////////
   // decode and read mux
   ////////////////////////////////////////
   csr_access #(
      .HART_ID_W (HART_ID_W)
   ) u_access (
      .csr_req   (csr_req),
      .trap_view (trap_view),
      .cnt_view  (cnt_view),
      .hart_id   (hart_id),
      .wr_sel    (wr_sel),
      .rdata     (rdata)
   );

   ////////////////////////////////////////
   // register banks
   ////////////////////////////////////////
   csr_trap_regs #(
      .PC_W (PC_W)
   ) u_trap_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_sel    (wr_sel),
      .wdata     (csr_req.wdata),
      .cmt       (cmt),
      .irq       (irq),
      .trap_view (trap_view),
      .irq_en    (irq_en)
   );

   csr_counters u_counters (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_sel      (wr_sel),
      .wdata       (csr_req.wdata),
      .instret_ena (cmt.instret_ena),
      .cnt_view    (cnt_view)
   );

   assign mtvec = trap_view.mtvec;  // trap vector to fetch
   assign mepc  = trap_view.mepc;   // mret target

endmodule

`default_nettype wire

//--- rtl/csr_trap_regs.sv
`default_nettype none
`timescale 1ns/1ps

module csr_trap_regs
   import csr_types_pkg::*, csr_map_pkg::*;
#(
   parameter int unsigned PC_W = 32   // implemented mepc/mtval bits
) (
   input  logic        clk,
   input  logic        rst_n,
   input  csr_wr_sel_t wr_sel,
   input  xlen_t       wdata,
   input  cmt_t        cmt,
   input  irq_t        irq,
   output trap_view_t  trap_view,
   output irq_en_t     irq_en
);

   logic                     status_mie_r;
   logic                     status_mpie_r;
   logic                     meie_r;
   logic                     mtie_r;
   logic                     msie_r;
   irq_t                     mip_r;        // sampled irq levels
   xlen_t                    mtvec_r;
   xlen_t                    mscratch_r;
   logic [PC_W-1:1]          epc_r;        // bit 0 always zero
   logic                     cause_int_r;
   logic [MCAUSE_CODE_W-1:0] cause_code_r;
   logic [PC_W-1:0]          badaddr_r;

   ////////////////////////////////////////
   // mstatus mie / mpie
   ////////////////////////////////////////
   // trap beats mret, mret beats csr write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status_mie_r  <= 1'b0;
         status_mpie_r <= 1'b0;
      end else if (cmt.status_ena) begin
         status_mie_r  <= 1'b0;          // interrupts off in handler
         status_mpie_r <= status_mie_r;  // remember previous mie
      end else if (cmt.mret_ena) begin
         status_mie_r  <= status_mpie_r;
         status_mpie_r <= 1'b1;
      end else if (wr_sel.mstatus) begin
         status_mie_r  <= wdata[MSTATUS_MIE_BIT];
         status_mpie_r <= wdata[MSTATUS_MPIE_BIT];
      end
   end

   ////////////////////////////////////////
   // mie, mip, mtvec, mscratch
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         meie_r     <= 1'b0;
         mtie_r     <= 1'b0;
         msie_r     <= 1'b0;
         mip_r      <= '0;
         mtvec_r    <= '0;
         mscratch_r <= '0;
      end else begin
         if (wr_sel.mie) begin    // only the three m-mode enables stick
            meie_r <= wdata[MEI_BIT];
            mtie_r <= wdata[MTI_BIT];
            msie_r <= wdata[MSI_BIT];
         end
         mip_r <= irq;            // read only, follows irq a cycle late
         if (wr_sel.mtvec)    mtvec_r    <= wdata;
         if (wr_sel.mscratch) mscratch_r <= wdata;
      end
   end

   ////////////////////////////////////////
   // mepc, mcause, mtval
   ////////////////////////////////////////
   // hardware commit wins over a csr write in the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epc_r        <= '0;
         cause_int_r  <= 1'b0;
         cause_code_r <= '0;
         badaddr_r    <= '0;
      end else begin
         if (cmt.epc_ena)        epc_r <= cmt.epc[PC_W-1:1];
         else if (wr_sel.mepc)   epc_r <= wdata[PC_W-1:1];

         if (cmt.cause_ena) begin
            cause_int_r  <= cmt.cause[MCAUSE_INT_BIT];
            cause_code_r <= cmt.cause[MCAUSE_CODE_W-1:0];
         end else if (wr_sel.mcause) begin
            cause_int_r  <= wdata[MCAUSE_INT_BIT];
            cause_code_r <= wdata[MCAUSE_CODE_W-1:0];
         end

         if (cmt.badaddr_ena)    badaddr_r <= cmt.badaddr[PC_W-1:0];
         else if (wr_sel.mtval)  badaddr_r <= wdata[PC_W-1:0];
      end
   end

   ////////////////////////////////////////
   // read views, zero filled to xlen
   ////////////////////////////////////////
   always_comb begin
      trap_view = '0;

      trap_view.mstatus[MSTATUS_MIE_BIT]        = status_mie_r;
      trap_view.mstatus[MSTATUS_MPIE_BIT]       = status_mpie_r;
      trap_view.mstatus[MSTATUS_MPP_LSB +: 2]   = MSTATUS_MPP_VAL; // fs, xs, sd stay 0

      trap_view.mie[MEI_BIT] = meie_r;
      trap_view.mie[MTI_BIT] = mtie_r;
      trap_view.mie[MSI_BIT] = msie_r;

      trap_view.mip[MEI_BIT] = mip_r.ext;
      trap_view.mip[MTI_BIT] = mip_r.tmr;
      trap_view.mip[MSI_BIT] = mip_r.sft;

      trap_view.mtvec    = mtvec_r;
      trap_view.mscratch = mscratch_r;
      trap_view.mepc     = xlen_t'({epc_r, 1'b0});
      trap_view.mtval    = xlen_t'(badaddr_r);

      trap_view.mcause[MCAUSE_INT_BIT]      = cause_int_r;
      trap_view.mcause[MCAUSE_CODE_W-1:0]   = cause_code_r;
   end

   // enables to the interrupt logic
   assign irq_en.status_mie = status_mie_r;
   assign irq_en.meie       = meie_r;
   assign irq_en.mtie       = mtie_r;
   assign irq_en.msie       = msie_r;

endmodule

`default_nettype wire

//--- rtl/csr_types_pkg.sv
`default_nettype none

package csr_types_pkg;

   localparam int unsigned XLEN = 32;

   typedef logic [XLEN-1:0]   xlen_t;
   typedef logic [11:0]       csr_idx_t;
   typedef logic [2*XLEN-1:0] cnt64_t;   // {hi, lo}

   // csr instruction access from the core
   typedef struct packed {
      logic     ena;
      logic     wr_en;
      logic     rd_en;
      csr_idx_t idx;
      xlen_t    wdata;
   } csr_req_t;

   // commit side events, one cycle pulses
   typedef struct packed {
      logic  status_ena;   // trap taken
      logic  mret_ena;
      logic  epc_ena;
      xlen_t epc;
      logic  cause_ena;
      xlen_t cause;
      logic  badaddr_ena;
      xlen_t badaddr;
      logic  instret_ena;  // one instruction retired
   } cmt_t;

   // raw interrupt levels
   typedef struct packed {
      logic ext;
      logic sft;
      logic tmr;
   } irq_t;

   // enables seen by the interrupt logic
   typedef struct packed {
      logic status_mie;
      logic meie;
      logic mtie;
      logic msie;
   } irq_en_t;

   // one qualified write strobe per writable csr
   typedef struct packed {
      logic mstatus;
      logic mie;
      logic mtvec;
      logic mscratch;
      logic mepc;
      logic mcause;
      logic mtval;
      logic mcycle;
      logic mcycleh;
      logic minstret;
      logic minstreth;
      logic counterstop;
   } csr_wr_sel_t;

   // read values out of csr_trap_regs
   typedef struct packed {
      xlen_t mstatus;
      xlen_t mie;
      xlen_t mip;
      xlen_t mtvec;
      xlen_t mscratch;
      xlen_t mepc;
      xlen_t mcause;
      xlen_t mtval;
   } trap_view_t;

   // read values out of csr_counters
   typedef struct packed {
      xlen_t mcycle;
      xlen_t mcycleh;
      xlen_t minstret;
      xlen_t minstreth;
      xlen_t counterstop;
   } cnt_view_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the csr unit testbench with verilator and run it
# exit status follows the simulation

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -Mdir obj_dir \
      --top-module csr_tb -f csr_unit.f -o csr_sim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/csr_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
   exit "$status"
fi
exit 0
